//--- logic/portal_config.svh
`ifndef PORTAL_CONFIG_SVH
`define PORTAL_CONFIG_SVH

// Bus field widths
`define PORTAL_ADDR_W 32
`define PORTAL_ID_W 6
`define PORTAL_LEN_W 4
`define PORTAL_DATA_W 32

// Loopback queue entries
`define PORTAL_QUEUE_DEPTH 4

// Control page constants
`define PORTAL_ID 5
`define PORTAL_FILLER 32'h005A05A0

`endif

//--- logic/portalPkg.sv
`include "portal_config.svh"

package portalPkg;

  typedef logic [`PORTAL_ADDR_W-1:0] axiAddrT;
  typedef logic [`PORTAL_ID_W-1:0] axiIdT;
  typedef logic [`PORTAL_LEN_W-1:0] burstLenT;
  typedef logic [`PORTAL_DATA_W-1:0] wordT;

  // Word index within a 32-byte page
  typedef logic [2:0] regIdxT;

  // Holds 0 to QUEUE_DEPTH entries
  typedef logic [2:0] queueCountT;

  // One word beat split out of a burst
  typedef struct packed {
    logic   ctrlPage;
    regIdxT regIdx;
    axiIdT  id;
    logic   last;
  } beatT;

  typedef struct packed {
    wordT  data;
    axiIdT id;
    logic  last;
  } readRspT;

  typedef struct packed {
    axiIdT id;
  } writeRspT;

endpackage

//--- logic/burstDecode.sv
`timescale 1ns/1ps

module burstDecode
  import portalPkg::*;
(
  input  logic     CLK,
  input  logic     RST_N,
  input  logic     addrValid,
  output logic     addrReady,
  input  axiAddrT  addr,
  input  axiIdT    id,
  input  burstLenT len,
  output logic     beatValid,
  input  logic     beatReady,
  output beatT     beat
);

  typedef enum logic {
    stateIdle,
    stateBusy
  } stateT;

  stateT    state;
  logic     ctrlPage;
  regIdxT   regIdx;
  axiIdT    burstId;
  burstLenT remaining;
  logic     addrFire;
  logic     beatFire;

  assign addrReady = (state == stateIdle);
  assign beatValid = (state == stateBusy);
  assign addrFire  = addrValid && addrReady;
  assign beatFire  = beatValid && beatReady;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      state <= stateIdle;
    end else if (addrFire) begin
      state <= stateBusy;
    end else if (beatFire && beat.last) begin
      state <= stateIdle;
    end
  end

  // Burst context, loaded at the address handshake
  always_ff @(posedge CLK) begin
    if (addrFire) begin
      ctrlPage  <= (addr[11:5] == 7'd0);
      regIdx    <= addr[4:2];
      burstId   <= id;
      remaining <= len;
    end else if (beatFire) begin
      // Index wraps within the page
      regIdx    <= regIdx + regIdxT'(1);
      remaining <= remaining - burstLenT'(1);
    end
  end

  assign beat.ctrlPage = ctrlPage;
  assign beat.regIdx   = regIdx;
  assign beat.id       = burstId;
  assign beat.last     = (remaining == '0);

endmodule

//--- logic/portalExecute.sv
`timescale 1ns/1ps

`include "portal_config.svh"

module portalExecute
  import portalPkg::*;
(
  input  logic     CLK,
  input  logic     RST_N,
  input  logic     rdBeatValid,
  output logic     rdBeatReady,
  input  beatT     rdBeat,
  input  logic     wrBeatValid,
  output logic     wrBeatReady,
  input  beatT     wrBeat,
  input  logic     wValid,
  output logic     wReady,
  input  wordT     wData,
  output logic     rdRspValid,
  output readRspT  rdRsp,
  input  logic     rdSpace,
  output logic     wrRspValid,
  output writeRspT wrRsp,
  input  logic     wrSpace,
  output logic     irq
);

  localparam int QueueDepth = `PORTAL_QUEUE_DEPTH;
  localparam int QueuePtrW  = $clog2(QueueDepth);

  wordT       wBuf [2];
  logic       wHead;
  logic       wTail;
  logic [1:0] wCount;
  logic       stageValid;
  wordT       stageData;

  wordT                 queueMem [QueueDepth];
  logic [QueuePtrW-1:0] queueHead;
  logic [QueuePtrW-1:0] queueTail;
  queueCountT           queueCount;
  logic                 queueEmpty;
  logic                 queueFull;
  logic                 queuePush;
  logic                 queuePop;

  logic intEnable;
  logic rdFire;
  logic wrFire;
  wordT rdValue;

  // Write data staging
  assign wReady     = (wCount != 2'd2);
  assign stageValid = (wCount != 2'd0);
  assign stageData  = wBuf[wHead];

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      wHead  <= 1'b0;
      wTail  <= 1'b0;
      wCount <= 2'd0;
    end else begin
      if (wValid && wReady) begin
        wTail <= !wTail;
      end
      if (wrFire) begin
        wHead <= !wHead;
      end
      wCount <= wCount + 2'(wValid && wReady) - 2'(wrFire);
    end
  end

  always_ff @(posedge CLK) begin
    if (wValid && wReady) begin
      wBuf[wTail] <= wData;
    end
  end

  // Beat acceptance
  assign rdBeatReady = rdSpace;
  assign rdFire      = rdBeatValid && rdBeatReady;
  assign wrBeatReady = stageValid && (wrBeat.ctrlPage || !queueFull) &&
                       (!wrBeat.last || wrSpace);
  assign wrFire      = wrBeatValid && wrBeatReady;

  // Loopback queue
  assign queueEmpty = (queueCount == '0);
  assign queueFull  = (queueCount == queueCountT'(QueueDepth));
  assign queuePush  = wrFire && !wrBeat.ctrlPage;
  assign queuePop   = rdFire && !rdBeat.ctrlPage && (rdBeat.regIdx == 3'd0) && !queueEmpty;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      queueHead  <= '0;
      queueTail  <= '0;
      queueCount <= '0;
      intEnable  <= 1'b0;
    end else begin
      if (queuePush) begin
        queueTail <= (queueTail == QueuePtrW'(QueueDepth - 1)) ? '0 : queueTail + 1'b1;
      end
      if (queuePop) begin
        queueHead <= (queueHead == QueuePtrW'(QueueDepth - 1)) ? '0 : queueHead + 1'b1;
      end
      queueCount <= queueCount + queueCountT'(queuePush) - queueCountT'(queuePop);
      if (wrFire && wrBeat.ctrlPage && (wrBeat.regIdx == 3'd1)) begin
        intEnable <= stageData[0];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (queuePush) begin
      queueMem[queueTail] <= stageData;
    end
  end

  // Register map for reads
  always_comb begin
    rdValue = '0;
    if (rdBeat.ctrlPage) begin
      case (rdBeat.regIdx)
        3'd0:    rdValue = wordT'(!queueEmpty);
        3'd1:    rdValue = wordT'(intEnable);
        3'd2:    rdValue = wordT'(1);
        3'd3:    rdValue = wordT'(queueCount);
        3'd4:    rdValue = wordT'(`PORTAL_ID);
        3'd5:    rdValue = wordT'(1);
        default: rdValue = `PORTAL_FILLER;
      endcase
    end else if (rdBeat.regIdx == 3'd0) begin
      rdValue = queueEmpty ? '0 : queueMem[queueHead];
    end else if (rdBeat.regIdx == 3'd1) begin
      rdValue = wordT'(!queueFull);
    end
  end

  assign rdRspValid = rdFire;
  assign rdRsp.data = rdValue;
  assign rdRsp.id   = rdBeat.id;
  assign rdRsp.last = rdBeat.last;

  // One B response per burst
  assign wrRspValid = wrFire && wrBeat.last;
  assign wrRsp.id   = wrBeat.id;

  assign irq = intEnable && !queueEmpty;

endmodule

//--- logic/portalResult.sv
`timescale 1ns/1ps

module portalResult
  import portalPkg::*;
(
  input  logic     CLK,
  input  logic     RST_N,
  input  logic     rdRspValid,
  input  readRspT  rdRsp,
  output logic     rdSpace,
  input  logic     wrRspValid,
  input  writeRspT wrRsp,
  output logic     wrSpace,
  output logic     rValid,
  input  logic     rReady,
  output wordT     rData,
  output axiIdT    rId,
  output logic     rLast,
  output logic     bValid,
  input  logic     bReady,
  output axiIdT    bId
);

  logic [1:0] push;
  logic [1:0] pop;
  logic [1:0] notFull;
  logic [1:0] notEmpty;
  logic [1:0] headPtr;
  logic [1:0] tailPtr;
  readRspT    rdMem [2];
  writeRspT   wrMem [2];

  // Channel 0 carries R, channel 1 carries B
  assign push[0] = rdRspValid && notFull[0];
  assign push[1] = wrRspValid && notFull[1];
  assign pop[0]  = rValid && rReady;
  assign pop[1]  = bValid && bReady;

  for (genvar ch = 0; ch < 2; ch++) begin : gFifo
    logic       head;
    logic       tail;
    logic [1:0] count;

    always_ff @(posedge CLK) begin
      if (!RST_N) begin
        head  <= 1'b0;
        tail  <= 1'b0;
        count <= 2'd0;
      end else begin
        if (push[ch]) begin
          tail <= !tail;
        end
        if (pop[ch]) begin
          head <= !head;
        end
        count <= count + 2'(push[ch]) - 2'(pop[ch]);
      end
    end

    assign notFull[ch]  = (count != 2'd2);
    assign notEmpty[ch] = (count != 2'd0);
    assign headPtr[ch]  = head;
    assign tailPtr[ch]  = tail;
  end

  always_ff @(posedge CLK) begin
    if (push[0]) begin
      rdMem[tailPtr[0]] <= rdRsp;
    end
    if (push[1]) begin
      wrMem[tailPtr[1]] <= wrRsp;
    end
  end

  assign rdSpace = notFull[0];
  assign wrSpace = notFull[1];

  assign rValid = notEmpty[0];
  assign rData  = rdMem[headPtr[0]].data;
  assign rId    = rdMem[headPtr[0]].id;
  assign rLast  = rdMem[headPtr[0]].last;

  assign bValid = notEmpty[1];
  assign bId    = wrMem[headPtr[1]].id;

endmodule

//--- logic/portalTop.sv
`timescale 1ns/1ps

module portalTop
  import portalPkg::*;
(
  input  logic     CLK,
  input  logic     RST_N,
  input  logic     awValid,
  output logic     awReady,
  input  axiAddrT  awAddr,
  input  axiIdT    awId,
  input  burstLenT awLen,
  input  logic     wValid,
  output logic     wReady,
  input  wordT     wData,
  output logic     bValid,
  input  logic     bReady,
  output axiIdT    bId,
  input  logic     arValid,
  output logic     arReady,
  input  axiAddrT  arAddr,
  input  axiIdT    arId,
  input  burstLenT arLen,
  output logic     rValid,
  input  logic     rReady,
  output wordT     rData,
  output axiIdT    rId,
  output logic     rLast,
  output logic     irq
);

  logic     rdBeatValid;
  logic     rdBeatReady;
  beatT     rdBeat;
  logic     wrBeatValid;
  logic     wrBeatReady;
  beatT     wrBeat;
  logic     rdRspValid;
  readRspT  rdRsp;
  logic     rdSpace;
  logic     wrRspValid;
  writeRspT wrRsp;
  logic     wrSpace;

  burstDecode rdDecode (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .addrValid (arValid),
    .addrReady (arReady),
    .addr      (arAddr),
    .id        (arId),
    .len       (arLen),
    .beatValid (rdBeatValid),
    .beatReady (rdBeatReady),
    .beat      (rdBeat)
  );

  burstDecode wrDecode (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .addrValid (awValid),
    .addrReady (awReady),
    .addr      (awAddr),
    .id        (awId),
    .len       (awLen),
    .beatValid (wrBeatValid),
    .beatReady (wrBeatReady),
    .beat      (wrBeat)
  );

  portalExecute execute (
    .CLK         (CLK),
    .RST_N       (RST_N),
    .rdBeatValid (rdBeatValid),
    .rdBeatReady (rdBeatReady),
    .rdBeat      (rdBeat),
    .wrBeatValid (wrBeatValid),
    .wrBeatReady (wrBeatReady),
    .wrBeat      (wrBeat),
    .wValid      (wValid),
    .wReady      (wReady),
    .wData       (wData),
    .rdRspValid  (rdRspValid),
    .rdRsp       (rdRsp),
    .rdSpace     (rdSpace),
    .wrRspValid  (wrRspValid),
    .wrRsp       (wrRsp),
    .wrSpace     (wrSpace),
    .irq         (irq)
  );

  portalResult result (
    .CLK        (CLK),
    .RST_N      (RST_N),
    .rdRspValid (rdRspValid),
    .rdRsp      (rdRsp),
    .rdSpace    (rdSpace),
    .wrRspValid (wrRspValid),
    .wrRsp      (wrRsp),
    .wrSpace    (wrSpace),
    .rValid     (rValid),
    .rReady     (rReady),
    .rData      (rData),
    .rId        (rId),
    .rLast      (rLast),
    .bValid     (bValid),
    .bReady     (bReady),
    .bId        (bId)
  );

endmodule

//--- verif/portalModel.svh
`ifndef PORTAL_MODEL_SVH
`define PORTAL_MODEL_SVH

`include "portal_config.svh"

// Expected loopback queue, oldest word first
wordT expQueue [$];
logic expEnable;

function automatic int freeSlots();
  return `PORTAL_QUEUE_DEPTH - expQueue.size();
endfunction

function automatic logic expIrq();
  return expEnable && (expQueue.size() != 0);
endfunction

// Effect of one write beat
function automatic void applyWrite(input logic ctrlPage, input regIdxT idx, input wordT data);
  if (ctrlPage) begin
    if (idx == 3'd1) begin
      expEnable = data[0];
    end
  end else begin
    expQueue.push_back(data);
  end
endfunction

// Value of one read beat; index 0 of the data page pops
function automatic wordT predictRead(input logic ctrlPage, input regIdxT idx);
  wordT value;
  value = '0;
  if (ctrlPage) begin
    case (idx)
      3'd0: value = wordT'(expQueue.size() != 0);
      3'd1: value = wordT'(expEnable);
      3'd2: value = 32'd1;
      3'd3: value = wordT'(expQueue.size());
      3'd4: value = `PORTAL_ID;
      3'd5: value = 32'd1;
      default: value = `PORTAL_FILLER;
    endcase
  end else if (idx == 3'd0) begin
    if (expQueue.size() != 0) begin
      value = expQueue.pop_front();
    end
  end else if (idx == 3'd1) begin
    value = wordT'(expQueue.size() < `PORTAL_QUEUE_DEPTH);
  end
  return value;
endfunction

`endif

//--- verif/tbPortal.sv
`timescale 1ns/1ps

`include "portal_config.svh"

module tbPortal
  import portalPkg::*;
();

  localparam int TxnCount   = 200;
  localparam int Directed   = 14;
  localparam int MaxBeats   = 4;
  localparam int BeatCycles = 40;
  localparam int WatchdogNs = (TxnCount + Directed) * MaxBeats * BeatCycles * 10;

  logic     CLK;
  logic     RST_N;
  logic     awValid;
  logic     awReady;
  axiAddrT  awAddr;
  axiIdT    awId;
  burstLenT awLen;
  logic     wValid;
  logic     wReady;
  wordT     wData;
  logic     bValid;
  logic     bReady;
  axiIdT    bId;
  logic     arValid;
  logic     arReady;
  axiAddrT  arAddr;
  axiIdT    arId;
  burstLenT arLen;
  logic     rValid;
  logic     rReady;
  wordT     rData;
  axiIdT    rId;
  logic     rLast;
  logic     irq;

  readRspT rGot [$];
  axiIdT   bGot [$];
  wordT    pending [$];
  int      errors;
  int      seed;
  int      stallSeed;

  `include "portalModel.svh"

  portalTop DUT (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // Random back-pressure on R and B
  always @(negedge CLK) begin
    if (RST_N) begin
      rReady = (($random(stallSeed) & 3) != 0);
      bReady = (($random(stallSeed) & 3) != 0);
    end
  end

  always @(posedge CLK) begin
    if (RST_N && rValid && rReady) begin
      rGot.push_back(readRspT'({rData, rId, rLast}));
    end
    if (RST_N && bValid && bReady) begin
      bGot.push_back(bId);
    end
  end

  task automatic compareValue(input wordT got, input wordT exp, input string what);
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Called on a falling edge; returns on the falling edge after the transfer
  task automatic issueAddr(input logic isWrite, input axiAddrT addr, input axiIdT id,
                           input burstLenT len);
    logic accepted;
    accepted = 1'b0;
    if (isWrite) begin
      awValid = 1'b1;
      awAddr  = addr;
      awId    = id;
      awLen   = len;
    end else begin
      arValid = 1'b1;
      arAddr  = addr;
      arId    = id;
      arLen   = len;
    end
    while (!accepted) begin
      #1;
      accepted = isWrite ? awReady : arReady;
      @(negedge CLK);
    end
    awValid = 1'b0;
    arValid = 1'b0;
  endtask

  task automatic sendData(input wordT data);
    logic accepted;
    accepted = 1'b0;
    wValid   = 1'b1;
    wData    = data;
    while (!accepted) begin
      #1;
      accepted = wReady;
      @(negedge CLK);
    end
    wValid = 1'b0;
  endtask

  task automatic runBurst(input logic isWrite, input axiAddrT addr, input axiIdT id,
                          input burstLenT len);
    logic    ctrlPage;
    regIdxT  idx;
    int      beats;
    int      i;
    wordT    data;
    readRspT rsp;
    ctrlPage = (addr[11:5] == 7'd0);
    idx      = addr[4:2];
    beats    = int'(len) + 1;
    assert (rGot.size() == 0 && bGot.size() == 0) else begin
      errors++;
      $display("Response beats arrived that no burst asked for, before %0t", $time);
    end
    rGot.delete();
    bGot.delete();
    issueAddr(isWrite, addr, id, len);
    if (isWrite) begin
      for (i = 0; i < beats; i++) begin
        data = (pending.size() != 0) ? pending.pop_front() : wordT'($random(seed));
        applyWrite(ctrlPage, idx + regIdxT'(i), data);
        sendData(data);
      end
      while (bGot.size() == 0) begin
        @(negedge CLK);
      end
      compareValue(wordT'(bGot.pop_front()), wordT'(id), "bId");
    end else begin
      while (rGot.size() < beats) begin
        @(negedge CLK);
      end
      for (i = 0; i < beats; i++) begin
        rsp = rGot.pop_front();
        compareValue(rsp.data, predictRead(ctrlPage, idx + regIdxT'(i)), "rData");
        compareValue(wordT'(rsp.id), wordT'(id), "rId");
        compareValue(wordT'(rsp.last), wordT'(i == beats - 1), "rLast");
      end
    end
    compareValue(wordT'(irq), wordT'(expIrq()), "irq");
  endtask

  function automatic axiAddrT pageAddr(input logic ctrl, input regIdxT idx);
    return {20'h0, ctrl ? 7'd0 : 7'd1, idx, 2'b00};
  endfunction

  initial begin
    int       txn;
    logic     isWrite;
    logic     ctrl;
    regIdxT   idx;
    burstLenT len;
    logic [6:0]  page;
    logic [19:0] upper;
    seed      = 32'h2a7d_33c7;
    stallSeed = seed ^ 32'h1357_9bdf;
    errors    = 0;
    expEnable = 1'b0;
    RST_N   = 1'b0;
    awValid = 1'b0;
    awAddr  = '0;
    awId    = '0;
    awLen   = '0;
    wValid  = 1'b0;
    wData   = '0;
    bReady  = 1'b1;
    arValid = 1'b0;
    arAddr  = '0;
    arId    = '0;
    arLen   = '0;
    rReady  = 1'b1;
    repeat (2) @(negedge CLK);
    RST_N = 1'b1;
    compareValue(wordT'(awReady), 32'd1, "awReady after reset");
    compareValue(wordT'(arReady), 32'd1, "arReady after reset");
    compareValue(wordT'(wReady), 32'd1, "wReady after reset");
    compareValue(wordT'(rValid), 32'd0, "rValid after reset");
    compareValue(wordT'(bValid), 32'd0, "bValid after reset");
    compareValue(wordT'(irq), 32'd0, "irq after reset");

    // Constant control words, then enable write and readback
    runBurst(1'b0, pageAddr(1'b1, 3'd2), 6'd1, 4'd0);
    runBurst(1'b0, pageAddr(1'b1, 3'd4), 6'd2, 4'd3);
    pending.push_back(32'h0000_0001);
    runBurst(1'b1, pageAddr(1'b1, 3'd1), 6'd3, 4'd0);
    runBurst(1'b0, pageAddr(1'b1, 3'd1), 6'd4, 4'd0);
    runBurst(1'b1, pageAddr(1'b1, 3'd3), 6'd5, 4'd1);
    runBurst(1'b0, pageAddr(1'b1, 3'd0), 6'd6, 4'd7);

    // Loopback order, count and empty reads
    runBurst(1'b1, pageAddr(1'b0, 3'd0), 6'd7, 4'd2);
    runBurst(1'b0, pageAddr(1'b1, 3'd3), 6'd8, 4'd0);
    runBurst(1'b0, pageAddr(1'b0, 3'd1), 6'd9, 4'd0);
    repeat (4) runBurst(1'b0, pageAddr(1'b0, 3'd0), 6'd10, 4'd0);
    pending.push_back(32'h0000_0000);
    runBurst(1'b1, pageAddr(1'b1, 3'd1), 6'd11, 4'd0);

    for (txn = 0; txn < TxnCount; txn++) begin
      isWrite = $random(seed) & 1;
      ctrl    = (($random(seed) & 3) == 0);
      idx     = regIdxT'($random(seed));
      len     = burstLenT'($random(seed) & 3);
      page    = ctrl ? 7'd0 : 7'($random(seed));
      upper   = 20'($random(seed));
      if (!ctrl && page == 7'd0) begin
        page = 7'd1;
      end
      if (!ctrl && !isWrite && (($random(seed) & 1) != 0)) begin
        idx = 3'd0;
      end
      // Data-page writes never exceed the free queue space
      if (isWrite && !ctrl) begin
        if (freeSlots() == 0) begin
          isWrite = 1'b0;
        end else if (int'(len) + 1 > freeSlots()) begin
          len = burstLenT'(freeSlots() - 1);
        end
      end
      runBurst(isWrite, {upper, page, idx, 2'b00}, axiIdT'($random(seed)), len);
    end
    assert (rGot.size() == 0 && bGot.size() == 0) else begin
      errors++;
      $display("Extra response beats arrived after the last burst");
    end

    $display("Finished %0d transactions with %0d errors", TxnCount + Directed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired because the DUT stopped completing bursts");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- all.f
+incdir+logic
+incdir+verif
logic/portalPkg.sv
logic/burstDecode.sv
logic/portalExecute.sv
logic/portalResult.sv
logic/portalTop.sv
verif/tbPortal.sv
